//--- aes_ctr_unit.f
aes_ctr_pkg.sv
ctr_fsm_pkg.sv
ctr_reg.sv
ctr_fsm.sv
ctr_cmd_ctrl.sv
aes_ctr_unit.sv
tb_aes_ctr_unit.sv

//--- Makefile
# Verilator build and run of the AES-CTR counter unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -j 0 --timescale 1ns/100ps \
		--top-module tb_aes_ctr_unit -f aes_ctr_unit.f
	-./obj_dir/Vtb_aes_ctr_unit > $(LOG) 2>&1
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_aes_ctr_unit.sv
/*
 * Testbench for the AES-CTR counter unit.
 * Clock, reset, directed and random commands, reference model,
 * result checker with random back-pressure, illegal-op check, timeout.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_aes_ctr_unit;

  import aes_ctr_pkg::*;
  import ctr_fsm_pkg::*;

  localparam logic [31:0] Seed        = 32'hc5321061;
  localparam int          NumDirected = 12;
  localparam int          NumRandom   = 200;
  // Directed, random and one illegal command
  localparam int          NumCmds     = NumDirected + NumRandom + 1;
  localparam int          CycleLimit  = NumCmds * 20 + 200;

  // DUT ports
  logic      clk_i;
  logic      rst_ni;
  logic      cmd_valid_i;
  logic      cmd_ready_o;
  ctr_op_e   cmd_op_i;
  ctr_word_u cmd_data_i;
  logic      ctr_valid_o;
  logic      ctr_ready_i;
  ctr_word_u ctr_o;
  logic      alert_o;

  // Model state and expected results in order
  ctr_word_u model;
  ctr_word_u exp_q[$];
  int        cycles       = 0;
  bit        bp_on        = 1'b0;

  aes_ctr_unit aes_ctr_unit_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .ctr_valid_o (ctr_valid_o),
    .ctr_ready_i (ctr_ready_i),
    .ctr_o       (ctr_o),
    .alert_o     (alert_o)
  );

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  // Load replaces, increment adds one mod 2^128
  function automatic ctr_word_u ref_ctr(ctr_word_u cur, ctr_op_e op, ctr_word_u data);
    ctr_word_u nxt;
    if (op == CTR_OP_LOAD) begin
      nxt = data;
    end else begin
      nxt.full = cur.full + 128'd1;
    end
    return nxt;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_ctr(input string name, input ctr_word_u exp, input ctr_word_u act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp.full, act.full);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Random word with an occasional run of all-ones low slices for long carries
  function automatic ctr_word_u rand_word();
    ctr_word_u   w;
    logic [31:0] rnd;
    w.full = {$urandom, $urandom, $urandom, $urandom};
    rnd    = $urandom;
    if (rnd[4:3] == 2'b00) begin
      for (int s = 0; s < NumSlices; s++) begin
        if (s < int'(rnd[2:0])) begin
          w.slice[s] = '1;
        end
      end
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // Command driver
  ////////////////////////////////////////

  // Hold the command until ready
  // Legal ops also advance the model
  task automatic send_cmd(input ctr_op_e op, input ctr_word_u data);
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_data_i  = data;
    while (!cmd_ready_o) begin
      @(negedge clk_i);
    end
    // Taken at the coming rising edge
    if (op == CTR_OP_LOAD || op == CTR_OP_INCR) begin
      model = ref_ctr(model, op, data);
      exp_q.push_back(model);
    end
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic load_incr(input ctr_word_u w);
    send_cmd(CTR_OP_LOAD, w);
    send_cmd(CTR_OP_INCR, '0);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  ////////////////////////////////////////
  // Result checker
  ////////////////////////////////////////

  // Outputs are stable at the falling edge
  initial begin : compare_results
    logic [31:0] rnd;
    ctr_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && ctr_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Result at %0t with no command outstanding", $time);
          abort_run();
        end else begin
          // Held value must match the head every cycle
          check_ctr("ctr_o", exp_q[0], ctr_o);
          check_bit("cmd_ready_o", 1'b0, cmd_ready_o);
        end
      end
      rnd         = $urandom;
      ctr_ready_i = bp_on ? rnd[0] : 1'b1;
      if (rst_ni && ctr_valid_o && ctr_ready_i) begin
        void'(exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : run_tests
    logic [31:0] rnd;
    ctr_word_u   w;
    rnd         = $urandom(Seed);
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = CTR_OP_LOAD;
    cmd_data_i  = '0;
    model       = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle outputs right after reset
    @(negedge clk_i);
    check_bit("cmd_ready_o", 1'b1, cmd_ready_o);
    check_bit("ctr_valid_o", 1'b0, ctr_valid_o);
    check_bit("alert_o", 1'b0, alert_o);

    // Directed loads and carries across slice boundaries
    load_incr(rand_word());
    w.full = 128'h0000FFFF;
    load_incr(w);
    send_cmd(CTR_OP_INCR, '0);
    w.full = 128'h0123_4567_89AB_CDEF_0000_FFFF_FFFF_FFFF;
    load_incr(w);
    w.full = 128'h0000_0000_0000_0000_FFFF_FFFF_FFFF_FFFF;
    load_incr(w);
    // Wrap to zero, then one
    w.full = '1;
    load_incr(w);
    send_cmd(CTR_OP_INCR, '0);
    wait_drain();

    // Random mix under back-pressure
    bp_on = 1'b1;
    repeat (NumRandom) begin
      rnd = $urandom;
      if (rnd[0]) begin
        send_cmd(CTR_OP_INCR, rand_word());
      end else begin
        send_cmd(CTR_OP_LOAD, rand_word());
      end
    end
    wait_drain();
    bp_on = 1'b0;

    // Illegal opcode raises a terminal alert
    rnd = $urandom;
    send_cmd(ctr_op_e'(rnd[0] ? 2'b11 : 2'b00), rand_word());
    while (!alert_o) begin
      @(negedge clk_i);
    end
    repeat (20) begin
      @(negedge clk_i);
      check_bit("alert_o", 1'b1, alert_o);
      check_bit("cmd_ready_o", 1'b0, cmd_ready_o);
      check_bit("ctr_valid_o", 1'b0, ctr_valid_o);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- aes_ctr_unit.sv
/*
 * AES-CTR slice-serial counter unit, top level.
 * Command front end, increment FSM and counter register.
 */

`timescale 1ns/100ps
`default_nettype none

module aes_ctr_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Command port
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  ctr_fsm_pkg::ctr_op_e   cmd_op_i,
  input  aes_ctr_pkg::ctr_word_u cmd_data_i,

  // Result port
  output logic                   ctr_valid_o,
  input  logic                   ctr_ready_i,
  output aes_ctr_pkg::ctr_word_u ctr_o,

  // Local fault, held until reset
  output logic                   alert_o
);

  import aes_ctr_pkg::*;

  // Front end to FSM
  logic                     incr;
  logic                     incr_err;
  logic                     idle;

  // Front end to register
  logic                     load_we;
  ctr_word_u                load_data;
  ctr_word_u                ctr_q;

  // FSM to register
  logic [SliceIdxWidth-1:0] slice_idx;
  logic [SliceSizeCtr-1:0]  slice_rd;
  logic [SliceSizeCtr-1:0]  slice_wr;
  logic                     slice_we;

  ////////////////////////////////////////
  // Command front end
  ////////////////////////////////////////

  ctr_cmd_ctrl ctr_cmd_ctrl_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .ctr_valid_o (ctr_valid_o),
    .ctr_ready_i (ctr_ready_i),
    .ctr_o       (ctr_o),
    .fsm_idle_i  (idle),
    .alert_i     (alert_o),
    .incr_o      (incr),
    .incr_err_o  (incr_err),
    .load_we_o   (load_we),
    .load_data_o (load_data),
    .ctr_q_i     (ctr_q)
  );

  ////////////////////////////////////////
  // Increment FSM and counter
  ////////////////////////////////////////

  ctr_fsm ctr_fsm_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .incr_err_i      (incr_err),
    .idle_o          (idle),
    .alert_o         (alert_o),
    .ctr_slice_idx_o (slice_idx),
    .ctr_slice_i     (slice_rd),
    .ctr_slice_o     (slice_wr),
    .ctr_we_o        (slice_we)
  );

  ctr_reg ctr_reg_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_we_i    (load_we),
    .load_data_i  (load_data),
    .slice_we_i   (slice_we),
    .slice_idx_i  (slice_idx),
    .slice_data_i (slice_wr),
    .slice_o      (slice_rd),
    .ctr_o        (ctr_q)
  );

endmodule

`default_nettype wire

//--- ctr_cmd_ctrl.sv
/*
 * Command front end of the AES-CTR counter unit.
 * Valid/ready command input, opcode decode, illegal-opcode detection,
 * increment sequencing and the valid/ready result output stage.
 */

`timescale 1ns/100ps
`default_nettype none

module ctr_cmd_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Command port
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  ctr_fsm_pkg::ctr_op_e   cmd_op_i,
  input  aes_ctr_pkg::ctr_word_u cmd_data_i,

  // Result port
  output logic                   ctr_valid_o,
  input  logic                   ctr_ready_i,
  output aes_ctr_pkg::ctr_word_u ctr_o,

  // Increment FSM handshake
  input  logic                   fsm_idle_i,
  input  logic                   alert_i,
  output logic                   incr_o,
  output logic                   incr_err_o,

  // Counter register access
  output logic                   load_we_o,
  output aes_ctr_pkg::ctr_word_u load_data_o,
  input  aes_ctr_pkg::ctr_word_u ctr_q_i
);

  import aes_ctr_pkg::*;
  import ctr_fsm_pkg::*;

  // Front end states
  localparam logic [1:0] IDLE      = 2'd0;
  localparam logic [1:0] LOAD      = 2'd1;
  localparam logic [1:0] WAIT_INCR = 2'd2;
  localparam logic [1:0] OUT       = 2'd3;

  logic [1:0] state_d, state_q;

  // Decoded op, then registered pulse one cycle later
  logic       incr_go_q, err_go_q;
  logic       incr_q, err_q;

  // Command word and held result
  ctr_word_u  data_q, out_q;

  logic       cmd_accept;
  logic       op_legal;
  logic       incr_done;

  ////////////////////////////////////////
  // Handshake and decode
  ////////////////////////////////////////

  // Only one command in flight, none after an alert
  assign cmd_ready_o = (state_q == IDLE) && !alert_i;
  assign cmd_accept  = cmd_valid_i && cmd_ready_o;
  assign op_legal    = (cmd_op_i == CTR_OP_LOAD) || (cmd_op_i == CTR_OP_INCR);

  // FSM back in idle after the start pulse went out
  // Illegal ops never get here, the FSM sits in error
  assign incr_done = (state_q == WAIT_INCR) && fsm_idle_i &&
                     !incr_go_q && !incr_q && !err_go_q && !err_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (cmd_accept) begin
          state_d = (cmd_op_i == CTR_OP_LOAD) ? LOAD : WAIT_INCR;
        end
      end
      LOAD:      state_d = OUT;
      WAIT_INCR: begin
        if (incr_done) begin
          state_d = OUT;
        end
      end
      OUT: begin
        // Result leaves on the output handshake
        if (ctr_ready_i) begin
          state_d = IDLE;
        end
      end
      default:   state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      incr_go_q <= 1'b0;
      err_go_q  <= 1'b0;
      incr_q    <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      state_q   <= state_d;
      incr_go_q <= cmd_accept && (cmd_op_i == CTR_OP_INCR);
      err_go_q  <= cmd_accept && !op_legal;
      // Start pulse only toward an idle FSM
      incr_q    <= incr_go_q && fsm_idle_i;
      err_q     <= err_go_q;
    end
  end

  ////////////////////////////////////////
  // Payload registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      data_q <= cmd_data_i;
    end
    // Load result is the word just written
    if (state_q == LOAD) begin
      out_q <= data_q;
    end else if (incr_done) begin
      out_q <= ctr_q_i;
    end
  end

  // Outputs
  assign load_we_o   = (state_q == LOAD);
  assign load_data_o = data_q;
  assign incr_o      = incr_q;
  assign incr_err_o  = err_q;
  assign ctr_valid_o = (state_q == OUT);
  assign ctr_o       = out_q;

endmodule

`default_nettype wire

//--- ctr_fsm.sv
/*
 * Slice-serial increment FSM for the AES-CTR counter.
 * Adds one to the counter a slice at a time, LSB slice first,
 * always walks all slices. Terminal error state raises alert_o.
 */

`timescale 1ns/100ps
`default_nettype none

module ctr_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Control from the command front end
  input  logic                                  incr_i,
  input  logic                                  incr_err_i,
  output logic                                  idle_o,
  output logic                                  alert_o,

  // Slice access to the counter register
  output logic [aes_ctr_pkg::SliceIdxWidth-1:0] ctr_slice_idx_o,
  input  logic [aes_ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_i,
  output logic [aes_ctr_pkg::SliceSizeCtr-1:0]  ctr_slice_o,
  output logic                                  ctr_we_o
);

  import aes_ctr_pkg::*;
  import ctr_fsm_pkg::*;

  // State and datapath registers
  ctr_state_e               state_d, state_q;
  logic [SliceIdxWidth-1:0] slice_idx_d, slice_idx_q;
  logic                     carry_d, carry_q;

  // Slice sum with carry-out on top
  logic [SliceSizeCtr:0]    slice_sum;

  ////////////////////////////////////////
  // Slice adder
  ////////////////////////////////////////

  // Carry in is one on the first slice
  assign slice_sum   = {1'b0, ctr_slice_i} + {{SliceSizeCtr{1'b0}}, carry_q};
  assign ctr_slice_o = slice_sum[SliceSizeCtr-1:0];

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    // Default outputs
    idle_o      = 1'b0;
    ctr_we_o    = 1'b0;
    alert_o     = 1'b0;

    // Hold by default
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    unique case (state_q)
      CTR_IDLE: begin
        idle_o = 1'b1;
        if (incr_i) begin
          // Start at slice 0 with carry set
          slice_idx_d = '0;
          carry_d     = 1'b1;
          state_d     = CTR_INCR;
        end
      end

      CTR_INCR: begin
        // Write back, pass carry on, step to next slice
        ctr_we_o    = 1'b1;
        carry_d     = slice_sum[SliceSizeCtr];
        slice_idx_d = slice_idx_q + SliceIdxWidth'(1);
        if (slice_idx_q == SliceIdxWidth'(NumSlices - 1)) begin
          state_d = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, left only by reset
        alert_o = 1'b1;
      end

      default: begin
        // Corrupted state code
        state_d = CTR_ERROR;
        alert_o = 1'b1;
      end
    endcase

    // Illegal command from the front end overrides everything
    if (incr_err_i) begin
      state_d = CTR_ERROR;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  // Index goes straight to the register read mux
  assign ctr_slice_idx_o = slice_idx_q;

endmodule

`default_nettype wire

//--- ctr_reg.sv
/*
 * Counter block register.
 * Whole-word load, indexed slice write and combinational slice read.
 */

`timescale 1ns/100ps
`default_nettype none

module ctr_reg (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Whole-word load from the command front end
  input  logic                                  load_we_i,
  input  aes_ctr_pkg::ctr_word_u                load_data_i,

  // Slice access from the increment FSM
  input  logic                                  slice_we_i,
  input  logic [aes_ctr_pkg::SliceIdxWidth-1:0] slice_idx_i,
  input  logic [aes_ctr_pkg::SliceSizeCtr-1:0]  slice_data_i,
  output logic [aes_ctr_pkg::SliceSizeCtr-1:0]  slice_o,

  // Full view for the output stage
  output aes_ctr_pkg::ctr_word_u                ctr_o
);

  import aes_ctr_pkg::*;

  // Counter storage
  ctr_word_u ctr_q;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Load wins over a slice write
  // Both never coincide in normal operation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctr_q <= '0;
    end else if (load_we_i) begin
      ctr_q <= load_data_i;
    end else if (slice_we_i) begin
      ctr_q.slice[slice_idx_i] <= slice_data_i;
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Current slice for the FSM adder
  assign slice_o = ctr_q.slice[slice_idx_i];

  // Whole word for result capture
  assign ctr_o = ctr_q;

endmodule

`default_nettype wire

//--- ctr_fsm_pkg.sv
/*
 * Control encodings of the AES-CTR counter unit.
 * Increment FSM state enum and command opcode enum.
 */

`default_nettype none

package ctr_fsm_pkg;

  ////////////////////////////////////////
  // Increment FSM states
  ////////////////////////////////////////

  // Hand-picked codes, every pair 4 bits apart
  // Any other 6-bit value is treated as a fault
  typedef enum logic [5:0] {
    CTR_IDLE  = 6'b011101,
    CTR_INCR  = 6'b110000,
    CTR_ERROR = 6'b001010
  } ctr_state_e;

  ////////////////////////////////////////
  // Command opcodes
  ////////////////////////////////////////

  // 2'b00 and 2'b11 are illegal
  typedef enum logic [1:0] {
    CTR_OP_LOAD = 2'b01,
    CTR_OP_INCR = 2'b10
  } ctr_op_e;

endpackage

`default_nettype wire

//--- aes_ctr_pkg.sv
/*
 * Data layout of the AES-CTR counter block.
 * Counter width, slice geometry and the counter word union
 * shared by the register, the increment FSM and the command front end.
 */

`default_nettype none

package aes_ctr_pkg;

  ////////////////////////////////////////
  // Counter geometry
  ////////////////////////////////////////

  // Full counter block, one AES block wide
  parameter int unsigned CtrWidth = 128;

  // Bits handled per increment step
  parameter int unsigned SliceSizeCtr = 16;

  // Steps per full increment
  parameter int unsigned NumSlices = CtrWidth / SliceSizeCtr;

  // Enough bits to address every slice
  parameter int unsigned SliceIdxWidth = $clog2(NumSlices);

  ////////////////////////////////////////
  // Counter word
  ////////////////////////////////////////

  // One 128-bit word, two views
  // full is used for whole-word load and result output,
  // slice is used by the serial increment, slice[0] is least significant
  typedef union packed {
    logic [CtrWidth-1:0]                      full;
    logic [NumSlices-1:0][SliceSizeCtr-1:0]   slice;
  } ctr_word_u;

endpackage

`default_nettype wire
